//--- all.f
logic/pulseSeqPkg.sv
logic/memBus.sv
logic/sharedRam.sv
logic/memArbiter.sv
logic/apbHost.sv
logic/sequencer.sv
logic/pulser.sv
logic/pulseSeqTop.sv
testbench/pulseSeq_props.sv
testbench/tbChecker.sv
testbench/tbTop.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbTop -f all.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- testbench/tbTop.sv
module tbTop;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 5;
	localparam int numTests = 6;
	localparam int maxWait = 16; // waits drawn from 0..15
	localparam int maxLoop = 4;
	localparam int maxDelay = 32;
	localparam int maxCharge = 16;
	localparam int maxInstr = 16; // executed per run, loop unrolled
	// two runs per test plus the APB loading of program and delay sets
	localparam int worstTestCycles = 2 * (maxInstr * (maxWait + 8)
		+ maxLoop * (maxDelay + maxCharge + 8)) + 8 * (maxInstr + 16 + 4);
	localparam int timeoutCycles = (numTests + 1) * worstTestCycles + 200;

	logic txCLK = 1'b0;
	logic rst;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [pulseSeqPkg::apbAddrWidth-1:0] pAddr;
	logic [pulseSeqPkg::apbDataWidth-1:0] pWdata;
	logic pReady;
	logic [pulseSeqPkg::apbDataWidth-1:0] pRdata;
	logic [7:0] trigOut;
	logic [7:0] ledOut;
	logic [pulseSeqPkg::numChannels-1:0] txOut;
	logic running;

	logic [31:0] rngState = 32'h56cf_2158;
	logic [63:0] prog[$];
	logic [63:0] setWords[16];
	logic [15:0] outVals[$];
	int outGaps[$];
	logic [63:0] fireDelays[$];
	int fireCharges[$];
	logic [15:0] lastOut = '0; // outputs hold their value between runs

	pulseSeqTop DUT (.*);

	tbChecker chk (.*);

	always #(clkPeriod / 2) txCLK = ~txCLK;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int randBelow(input int n);
		rngState = xorshift(rngState);
		return int'(rngState % n);
	endfunction

	function automatic logic [15:0] pickOutputs(input logic [15:0] avoidA,
		input logic [15:0] avoidB);
		logic [15:0] value;
		value = 16'(randBelow(65536));
		while (value == avoidA || value == avoidB) // every set must be a visible change
			value = 16'(randBelow(65536));
		return value;
	endfunction

	function automatic logic [63:0] makeInstr(input logic [3:0] op,
		input pulseSeqPkg::instrArg arg, input int waitCycles);
		pulseSeqPkg::instruction ins;
		ins = '0;
		ins.opcode = op;
		ins.arg = arg;
		ins.waitCycles = 16'(waitCycles);
		return ins;
	endfunction

	task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data);
		@(posedge txCLK);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= 1'b1;
		pAddr <= addr;
		pWdata <= data;
		@(posedge txCLK);
		pEnable <= 1'b1;
		@(negedge txCLK);
		while (!pReady) // high half waits for the memory grant
			@(negedge txCLK);
		@(posedge txCLK);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic apbRead(input logic [7:0] addr, output logic [31:0] data);
		@(posedge txCLK);
		pSel <= 1'b1;
		pEnable <= 1'b0;
		pWrite <= 1'b0;
		pAddr <= addr;
		@(posedge txCLK);
		pEnable <= 1'b1;
		@(negedge txCLK);
		while (!pReady)
			@(negedge txCLK);
		data = pRdata;
		@(posedge txCLK);
		pSel <= 1'b0;
		pEnable <= 1'b0;
	endtask

	task automatic writeWord(input logic [pulseSeqPkg::memAddrWidth-1:0] addr,
		input logic [63:0] data);
		apbWrite({addr, 1'b0}, data[31:0]); // low half is only held
		apbWrite({addr, 1'b1}, data[63:32]);
	endtask

	// random program and the events it should produce
	task automatic buildProgram();
		pulseSeqPkg::instrArg arg;
		logic [15:0] firstVal;
		logic [15:0] prevVal;
		int prevWait;
		int w;
		int loops;
		int numSets;
		prog.delete();
		outVals.delete();
		outGaps.delete();
		fireDelays.delete();
		fireCharges.delete();
		for (int s = 0; s < 16; s++)
			for (int c = 0; c < pulseSeqPkg::numChannels; c++)
				setWords[s][8*c +: 8] = 8'(randBelow(maxDelay));
		numSets = 1 + randBelow(3);
		prevVal = lastOut;
		prevWait = 0;
		firstVal = '0;
		for (int k = 0; k < numSets; k++)
		begin
			arg = pickOutputs(prevVal, prevVal);
			w = randBelow(maxWait);
			prog.push_back(makeInstr(pulseSeqPkg::opSetOutputs, arg, w));
			outVals.push_back({arg.outputs.trig, arg.outputs.led});
			outGaps.push_back(k == 0 ? 0 : prevWait);
			if (k == 0)
				firstVal = arg;
			prevVal = arg;
			prevWait = w;
		end
		if (randBelow(2) == 1)
			prog.push_back(makeInstr(pulseSeqPkg::opNop, '0, randBelow(maxWait)));
		loops = 1 + randBelow(maxLoop);
		arg = '0;
		arg.loopCount = 16'(loops);
		prog.push_back(makeInstr(pulseSeqPkg::opLoopStart, arg, randBelow(maxWait)));
		arg = '0;
		arg.fire.setIdx = 4'(randBelow(16));
		arg.fire.chargeTime = 12'(1 + randBelow(maxCharge));
		prog.push_back(makeInstr(pulseSeqPkg::opFire, arg, randBelow(maxWait)));
		prog.push_back(makeInstr(pulseSeqPkg::opLoopEnd, '0, randBelow(maxWait)));
		repeat (loops)
		begin
			fireDelays.push_back(setWords[arg.fire.setIdx]);
			fireCharges.push_back(int'(arg.fire.chargeTime));
		end
		// last value differs from the first so a rerun shows every change
		arg = pickOutputs(prevVal, firstVal);
		prog.push_back(makeInstr(pulseSeqPkg::opSetOutputs, arg, randBelow(maxWait)));
		outVals.push_back({arg.outputs.trig, arg.outputs.led});
		outGaps.push_back(prevWait);
		prog.push_back(makeInstr(pulseSeqPkg::opEnd, '0, 0));
		lastOut = arg;
	endtask

	task automatic handModel();
		foreach (outVals[i])
			chk.expectOutput(outVals[i], outGaps[i]);
		foreach (fireDelays[i])
			chk.expectFiring(fireDelays[i], fireCharges[i]);
	endtask

	task automatic runProgram();
		logic [31:0] status;
		apbWrite(pulseSeqPkg::apbCtrlAddr, 32'd1);
		@(negedge txCLK);
		while (!running)
			@(negedge txCLK);
		apbRead(pulseSeqPkg::apbCtrlAddr, status);
		chk.checkValue("status while running", 64'd1, 64'(status));
		while (running)
			@(negedge txCLK);
		repeat (3) @(posedge txCLK);
	endtask

	task automatic runTest(input int t);
		logic [31:0] status;
		buildProgram();
		for (int a = 0; a < prog.size(); a++)
			writeWord(pulseSeqPkg::programBase + 7'(a), prog[a]);
		for (int s = 0; s < 16; s++)
			writeWord(pulseSeqPkg::delayBase + 7'(s), setWords[s]);
		for (int r = 0; r < 2; r++) // second start must repeat the first run
		begin
			handModel();
			apbRead(pulseSeqPkg::apbCtrlAddr, status);
			chk.checkValue("status before start", 64'd0, 64'(status));
			runProgram();
		end
		chk.endTest($sformatf("program %0d of %0d words, run twice", t, prog.size()));
	endtask

	initial
	begin
		#(timeoutCycles * clkPeriod);
		$display("timeout: the run did not finish within %0d cycles", timeoutCycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] status;
		rst <= 1'b1;
		pSel <= 1'b0;
		pEnable <= 1'b0;
		pWrite <= 1'b0;
		pAddr <= '0;
		pWdata <= '0;
		repeat (resetCycles) @(posedge txCLK);
		rst <= 1'b0;
		@(negedge txCLK);
		chk.checkIdle();
		chk.checkValue("pReady", 64'd1, 64'(pReady)); // idle bus never stalls
		apbRead(pulseSeqPkg::apbCtrlAddr, status);
		chk.checkValue("status after reset", 64'd0, 64'(status));
		chk.endTest("reset state");
		for (int t = 1; t <= numTests; t++)
			runTest(t);
		chk.printCounts();
		if (chk.errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- testbench/tbChecker.sv
module tbChecker (
	input logic txCLK,
	input logic rst,
	input logic [7:0] trigOut,
	input logic [7:0] ledOut,
	input logic [pulseSeqPkg::numChannels-1:0] txOut,
	input logic running
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [15:0] expOut[$]; // {trig, led} in program order
	int expGap[$];
	logic [63:0] expDelays[$];
	int expCharge[$];
	logic [15:0] lastOut;
	logic [pulseSeqPkg::numChannels-1:0] lastTx;
	logic [pulseSeqPkg::numChannels-1:0] doneMask; // channels finished this firing
	int riseCyc[pulseSeqPkg::numChannels];
	int fallCyc[pulseSeqPkg::numChannels];
	int cycleCount = 0;
	int lastChange = 0;
	int errorCount = 0;
	int testErrors = 0;
	int testCount = 0;
	int failedTests = 0;

	task automatic noteError();
		errorCount++;
		testErrors++;
	endtask

	task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act)
		begin
			$display("Fail %0t %s expected %0h got %0h", $time, name, exp, act);
			noteError();
		end
	endtask

	task automatic checkIdle();
		checkValue("trigOut", 64'd0, 64'(trigOut));
		checkValue("ledOut", 64'd0, 64'(ledOut));
		checkValue("txOut", 64'd0, 64'(txOut));
		checkValue("running", 64'd0, 64'(running));
	endtask

	task automatic expectOutput(input logic [15:0] value, input int gap);
		expOut.push_back(value);
		expGap.push_back(gap);
	endtask

	task automatic expectFiring(input logic [63:0] delays, input int charge);
		expDelays.push_back(delays);
		expCharge.push_back(charge);
	endtask

	task automatic checkOutputChange();
		logic [15:0] value;
		int gap;
		value = {trigOut, ledOut};
		if (expOut.size() == 0)
		begin
			$display("outputs changed to %h at %0t but no change was expected", value, $time);
			noteError();
		end
		else
		begin
			checkValue("trigOut/ledOut", 64'(expOut.pop_front()), 64'(value));
			gap = expGap.pop_front();
			if (cycleCount - lastChange < gap)
			begin
				$display("Fail %0t output gap expected at least %0d got %0d", $time, gap,
					cycleCount - lastChange);
				noteError();
			end
		end
		lastChange = cycleCount;
		lastOut = value;
	endtask

	// widths absolute, rises relative to the earliest channel
	task automatic checkFiring();
		logic [63:0] delays;
		int charge;
		int firstRise;
		int minDelay;
		if (expDelays.size() == 0)
		begin
			$display("txOut fired at %0t but the program asked for no firing", $time);
			noteError();
		end
		else
		begin
			delays = expDelays.pop_front();
			charge = expCharge.pop_front();
			firstRise = riseCyc[0];
			minDelay = int'(delays[7:0]);
			for (int i = 1; i < pulseSeqPkg::numChannels; i++)
			begin
				if (riseCyc[i] < firstRise)
					firstRise = riseCyc[i];
				if (int'(delays[8*i +: 8]) < minDelay)
					minDelay = int'(delays[8*i +: 8]);
			end
			for (int i = 0; i < pulseSeqPkg::numChannels; i++)
			begin
				checkValue($sformatf("txOut[%0d] width", i), 64'(charge),
					64'(fallCyc[i] - riseCyc[i]));
				checkValue($sformatf("txOut[%0d] rise offset", i),
					64'(int'(delays[8*i +: 8]) - minDelay), 64'(riseCyc[i] - firstRise));
			end
		end
	endtask

	task automatic endTest(input string name);
		if (expOut.size() != 0)
		begin
			$display("%s: %0d expected output changes never appeared", name, expOut.size());
			noteError();
		end
		if (expDelays.size() != 0)
		begin
			$display("%s: %0d expected firings never happened", name, expDelays.size());
			noteError();
		end
		expOut.delete();
		expGap.delete();
		expDelays.delete();
		expCharge.delete();
		testCount++;
		if (testErrors == 0)
			$display("test %0d %s: ok", testCount, name);
		else
		begin
			$display("test %0d %s: %0d errors", testCount, name, testErrors);
			failedTests++;
		end
		testErrors = 0;
	endtask

	task automatic printCounts();
		$display("%0d tests, %0d passed, %0d failed, %0d errors in total", testCount,
			testCount - failedTests, failedTests, errorCount);
	endtask

	// outputs settle after the rising edge, look at them on the falling one
	always @(negedge txCLK)
	begin
		cycleCount++;
		if (rst)
		begin
			lastOut = {trigOut, ledOut};
			lastTx = '0;
			doneMask = '0;
		end
		else
		begin
			if ({trigOut, ledOut} !== lastOut)
				checkOutputChange();
			for (int i = 0; i < pulseSeqPkg::numChannels; i++)
			begin
				if (txOut[i] && !lastTx[i])
					riseCyc[i] = cycleCount;
				if (!txOut[i] && lastTx[i])
				begin
					fallCyc[i] = cycleCount;
					doneMask[i] = 1'b1;
				end
			end
			lastTx = txOut;
			if (&doneMask)
			begin
				checkFiring();
				doneMask = '0;
			end
		end
	end

endmodule

//--- testbench/pulseSeq_props.sv
module pulseSeqProps (
	input logic txCLK,
	input logic rst,
	input logic hostReq,
	input logic fetchReq,
	input logic delayReq,
	input logic hostGrant,
	input logic fetchGrant,
	input logic delayGrant,
	input logic busy,
	input logic [pulseSeqPkg::numChannels-1:0] txOut
);
	timeunit 1ns;
	timeprecision 100ps;

	// single port memory, at most one winner per cycle
	grantOneHot: assert property (@(posedge txCLK) disable iff (rst)
		$onehot0({delayGrant, fetchGrant, hostGrant}))
		else $error("more than one requester granted in the same cycle");

	noIdleGrant: assert property (@(posedge txCLK) disable iff (rst)
		(!delayGrant || delayReq) && (!fetchGrant || fetchReq) && (!hostGrant || hostReq))
		else $error("grant given to a requester that was not asking");

	quietWhenIdle: assert property (@(posedge txCLK) disable iff (rst)
		!busy |-> txOut == '0)
		else $error("txOut active while the pulser is idle");

endmodule

bind pulseSeqTop pulseSeqProps props (
	.txCLK(txCLK),
	.rst(rst),
	.hostReq(hostBus.reqValid),
	.fetchReq(fetchBus.reqValid),
	.delayReq(delayBus.reqValid),
	.hostGrant(hostBus.grant),
	.fetchGrant(fetchBus.grant),
	.delayGrant(delayBus.grant),
	.busy(busy),
	.txOut(txOut)
);

//--- logic/pulseSeqTop.sv
module pulseSeqTop (
	input logic txCLK,
	input logic rst,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [pulseSeqPkg::apbAddrWidth-1:0] pAddr,
	input logic [pulseSeqPkg::apbDataWidth-1:0] pWdata,
	output logic pReady,
	output logic [pulseSeqPkg::apbDataWidth-1:0] pRdata,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic [pulseSeqPkg::numChannels-1:0] txOut,
	output logic running
);

	memBus hostBus ();
	memBus fetchBus ();
	memBus delayBus ();

	logic start;
	logic fireStart;
	logic busy;
	pulseSeqPkg::instrArg fireArg;
	logic ramEn;
	logic ramWrite;
	logic [pulseSeqPkg::memAddrWidth-1:0] ramAddr;
	logic [pulseSeqPkg::wordWidth-1:0] ramWdata;
	logic [pulseSeqPkg::wordWidth-1:0] ramRdata;

	apbHost uHost (
		.txCLK(txCLK),
		.rst(rst),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWdata(pWdata),
		.pReady(pReady),
		.pRdata(pRdata),
		.hostBus(hostBus.requester),
		.running(running),
		.start(start)
	);

	sequencer uSeq (
		.txCLK(txCLK),
		.rst(rst),
		.start(start),
		.fetchBus(fetchBus.requester),
		.fireStart(fireStart),
		.fireArg(fireArg),
		.busy(busy),
		.trigOut(trigOut),
		.ledOut(ledOut),
		.running(running)
	);

	pulser uPulser (
		.txCLK(txCLK),
		.rst(rst),
		.fireStart(fireStart),
		.fireArg(fireArg),
		.delayBus(delayBus.requester),
		.busy(busy),
		.txOut(txOut)
	);

	memArbiter uArb (
		.txCLK(txCLK),
		.rst(rst),
		.hostBus(hostBus.arbiter),
		.fetchBus(fetchBus.arbiter),
		.delayBus(delayBus.arbiter),
		.ramEn(ramEn),
		.ramWrite(ramWrite),
		.ramAddr(ramAddr),
		.ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

	sharedRam uRam (
		.txCLK(txCLK),
		.ramEn(ramEn),
		.ramWrite(ramWrite),
		.ramAddr(ramAddr),
		.ramWdata(ramWdata),
		.ramRdata(ramRdata)
	);

endmodule

//--- logic/pulser.sv
module pulser (
	input logic txCLK,
	input logic rst,
	input logic fireStart,
	input pulseSeqPkg::instrArg fireArg,
	memBus.requester delayBus,
	output logic busy,
	output logic [pulseSeqPkg::numChannels-1:0] txOut
);

	logic [pulseSeqPkg::numChannels-1:0][pulseSeqPkg::delayWidth-1:0] delays;
	logic [pulseSeqPkg::chargeWidth-1:0] chargeTime;
	logic [pulseSeqPkg::memAddrWidth-1:0] setAddr;
	logic [pulseSeqPkg::pulseCntWidth-1:0] cnt;
	logic [pulseSeqPkg::numChannels-1:0][pulseSeqPkg::pulseCntWidth-1:0] riseAt;
	logic [pulseSeqPkg::numChannels-1:0][pulseSeqPkg::pulseCntWidth-1:0] fallAt;
	logic [pulseSeqPkg::numChannels-1:0] chanDone;
	logic delayReq;
	logic wordPhase;
	logic firing;

	assign delayBus.reqValid = delayReq;
	assign delayBus.reqWrite = 1'b0;
	assign delayBus.reqAddr = setAddr;
	assign delayBus.reqWdata = '0;

	// one shared counter, compared per channel
	always_comb
	begin
		for (int i = 0; i < pulseSeqPkg::numChannels; i++)
		begin
			riseAt[i] = {{(pulseSeqPkg::pulseCntWidth - pulseSeqPkg::delayWidth){1'b0}}, delays[i]};
			fallAt[i] = riseAt[i]
				+ {{(pulseSeqPkg::pulseCntWidth - pulseSeqPkg::chargeWidth){1'b0}}, chargeTime};
			txOut[i] = firing && cnt >= riseAt[i] && cnt < fallAt[i];
			chanDone[i] = cnt >= fallAt[i];
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			delayReq <= 1'b0;
			wordPhase <= 1'b0;
			firing <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			if (fireStart && !busy)
			begin
				busy <= 1'b1;
				delayReq <= 1'b1;
			end
			if (delayReq && delayBus.grant)
			begin
				delayReq <= 1'b0;
				wordPhase <= 1'b1;
			end
			if (wordPhase)
			begin
				wordPhase <= 1'b0;
				firing <= 1'b1;
			end
			if (firing && &chanDone) // all channels back low
			begin
				firing <= 1'b0;
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (fireStart && !busy)
		begin
			setAddr <= pulseSeqPkg::delayBase
				+ {{(pulseSeqPkg::memAddrWidth - pulseSeqPkg::setIdxWidth){1'b0}},
				fireArg.fire.setIdx};
			chargeTime <= fireArg.fire.chargeTime;
		end
		if (wordPhase)
		begin
			delays <= delayBus.rdata;
			cnt <= '0;
		end
		else if (firing)
			cnt <= cnt + 1'b1;
	end

endmodule

//--- logic/sequencer.sv
module sequencer (
	input logic txCLK,
	input logic rst,
	input logic start,
	memBus.requester fetchBus,
	output logic fireStart,
	output pulseSeqPkg::instrArg fireArg,
	input logic busy,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic running
);

	pulseSeqPkg::instruction cur;
	logic [pulseSeqPkg::memAddrWidth-1:0] pc;
	logic [pulseSeqPkg::memAddrWidth-1:0] loopAddr;
	logic [15:0] loopCount;
	logic [pulseSeqPkg::waitWidth-1:0] waitCnt;
	logic fetchReq;
	logic dataPhase; // rdata holds the fetched word
	logic waiting;

	assign cur = fetchBus.rdata;

	assign fetchBus.reqValid = fetchReq;
	assign fetchBus.reqWrite = 1'b0;
	assign fetchBus.reqAddr = pc;
	assign fetchBus.reqWdata = '0;

	always_ff @(posedge txCLK)
	begin
		if (rst)
		begin
			running <= 1'b0;
			fetchReq <= 1'b0;
			dataPhase <= 1'b0;
			waiting <= 1'b0;
			waitCnt <= '0;
			fireStart <= 1'b0;
			trigOut <= 8'h00;
			ledOut <= 8'h00;
			pc <= pulseSeqPkg::programBase;
			loopCount <= 16'd0;
		end
		else
		begin
			fireStart <= 1'b0;
			if (start && !running)
			begin
				running <= 1'b1;
				pc <= pulseSeqPkg::programBase;
				fetchReq <= 1'b1;
			end
			if (fetchReq && fetchBus.grant)
			begin
				fetchReq <= 1'b0;
				dataPhase <= 1'b1;
			end
			if (dataPhase)
			begin
				dataPhase <= 1'b0;
				waitCnt <= cur.waitCycles;
				waiting <= 1'b1;
				pc <= pc + 1'b1;
				case (cur.opcode)
					pulseSeqPkg::opNop: ; // only the wait
					pulseSeqPkg::opSetOutputs:
					begin
						trigOut <= cur.arg.outputs.trig;
						ledOut <= cur.arg.outputs.led;
					end
					pulseSeqPkg::opFire:
						fireStart <= 1'b1;
					pulseSeqPkg::opLoopStart:
						loopCount <= cur.arg.loopCount;
					pulseSeqPkg::opLoopEnd:
					begin
						if (loopCount > 16'd1)
						begin
							pc <= loopAddr; // back to the body
							loopCount <= loopCount - 1'b1;
						end
					end
					pulseSeqPkg::opEnd:
					begin
						running <= 1'b0;
						waiting <= 1'b0;
					end
					default: ; // undefined codes behave as a nop
				endcase
			end
			if (waiting)
			begin
				if (waitCnt != '0)
					waitCnt <= waitCnt - 1'b1;
				else if (!busy && !fireStart) // pulser back-pressure
				begin
					waiting <= 1'b0;
					fetchReq <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge txCLK)
	begin
		if (dataPhase && cur.opcode == pulseSeqPkg::opFire)
			fireArg <= cur.arg;
		if (dataPhase && cur.opcode == pulseSeqPkg::opLoopStart)
			loopAddr <= pc + 1'b1; // first instruction of the body
	end

endmodule

//--- logic/apbHost.sv
module apbHost (
	input logic txCLK,
	input logic rst,
	input logic pSel,
	input logic pEnable,
	input logic pWrite,
	input logic [pulseSeqPkg::apbAddrWidth-1:0] pAddr,
	input logic [pulseSeqPkg::apbDataWidth-1:0] pWdata,
	output logic pReady,
	output logic [pulseSeqPkg::apbDataWidth-1:0] pRdata,
	memBus.requester hostBus,
	input logic running,
	output logic start
);

	logic access;
	logic isCtrl;
	logic memWrite;
	logic highWrite;
	logic [pulseSeqPkg::apbDataWidth-1:0] lowHalf;

	assign access = pSel && pEnable;
	assign isCtrl = pAddr == pulseSeqPkg::apbCtrlAddr;
	assign memWrite = access && pWrite && !isCtrl;
	assign highWrite = memWrite && pAddr[0]; // odd address completes the word

	// request held by the APB master until pReady
	assign hostBus.reqValid = highWrite;
	assign hostBus.reqWrite = 1'b1;
	assign hostBus.reqAddr = pAddr[pulseSeqPkg::apbAddrWidth-1:1];
	assign hostBus.reqWdata = {pWdata, lowHalf};

	assign pReady = !highWrite || hostBus.grant;

	// status only, memory is not readable
	assign pRdata = isCtrl ? {{(pulseSeqPkg::apbDataWidth-1){1'b0}}, running} : '0;

	always_ff @(posedge txCLK)
	begin
		if (memWrite && !pAddr[0])
			lowHalf <= pWdata;
	end

	always_ff @(posedge txCLK)
	begin
		if (rst)
			start <= 1'b0;
		else
			start <= access && pWrite && isCtrl && pWdata[0]; // single cycle pulse
	end

endmodule

//--- logic/memArbiter.sv
module memArbiter (
	input logic txCLK,
	input logic rst,
	memBus.arbiter hostBus,
	memBus.arbiter fetchBus,
	memBus.arbiter delayBus,
	output logic ramEn,
	output logic ramWrite,
	output logic [pulseSeqPkg::memAddrWidth-1:0] ramAddr,
	output logic [pulseSeqPkg::wordWidth-1:0] ramWdata,
	input logic [pulseSeqPkg::wordWidth-1:0] ramRdata
);

	logic delayGnt;
	logic fetchGnt;
	logic hostGnt;
	logic [2:0] readOwner; // delay, fetch, host

	// pulser first so a firing never waits
	assign delayGnt = delayBus.reqValid;
	assign fetchGnt = fetchBus.reqValid && !delayBus.reqValid;
	assign hostGnt = hostBus.reqValid && !delayBus.reqValid && !fetchBus.reqValid;

	assign delayBus.grant = delayGnt;
	assign fetchBus.grant = fetchGnt;
	assign hostBus.grant = hostGnt;

	assign ramEn = delayGnt || fetchGnt || hostGnt;

	always_comb
	begin
		ramWrite = hostBus.reqWrite;
		ramAddr = hostBus.reqAddr;
		ramWdata = hostBus.reqWdata;
		if (delayGnt)
		begin
			ramWrite = delayBus.reqWrite;
			ramAddr = delayBus.reqAddr;
			ramWdata = delayBus.reqWdata;
		end
		else if (fetchGnt)
		begin
			ramWrite = fetchBus.reqWrite;
			ramAddr = fetchBus.reqAddr;
			ramWdata = fetchBus.reqWdata;
		end
	end

	// remember who read so the data lands on one port only
	always_ff @(posedge txCLK)
	begin
		if (rst)
			readOwner <= 3'b000;
		else
			readOwner <= {delayGnt && !delayBus.reqWrite, fetchGnt && !fetchBus.reqWrite,
				hostGnt && !hostBus.reqWrite};
	end

	assign delayBus.rdata = readOwner[2] ? ramRdata : '0;
	assign fetchBus.rdata = readOwner[1] ? ramRdata : '0;
	assign hostBus.rdata = readOwner[0] ? ramRdata : '0;

endmodule

//--- logic/sharedRam.sv
module sharedRam (
	input logic txCLK,
	input logic ramEn,
	input logic ramWrite,
	input logic [pulseSeqPkg::memAddrWidth-1:0] ramAddr,
	input logic [pulseSeqPkg::wordWidth-1:0] ramWdata,
	output logic [pulseSeqPkg::wordWidth-1:0] ramRdata
);

	// program in the low half, delay sets from word 64 up
	logic [pulseSeqPkg::wordWidth-1:0] mem [pulseSeqPkg::memDepth];

	always_ff @(posedge txCLK)
	begin
		if (ramEn)
		begin
			if (ramWrite)
				mem[ramAddr] <= ramWdata;
			else
				ramRdata <= mem[ramAddr]; // one cycle read latency
		end
	end

endmodule

//--- logic/memBus.sv
interface memBus;

	logic reqValid;
	logic reqWrite;
	logic [pulseSeqPkg::memAddrWidth-1:0] reqAddr;
	logic [pulseSeqPkg::wordWidth-1:0] reqWdata;
	logic grant; // one cycle, access happens on that edge
	logic [pulseSeqPkg::wordWidth-1:0] rdata; // valid the cycle after grant

	modport requester (
		output reqValid,
		output reqWrite,
		output reqAddr,
		output reqWdata,
		input grant,
		input rdata
	);

	modport arbiter (
		input reqValid,
		input reqWrite,
		input reqAddr,
		input reqWdata,
		output grant,
		output rdata
	);

endinterface

//--- logic/pulseSeqPkg.sv
package pulseSeqPkg;

	localparam int numChannels = 8;
	localparam int wordWidth = 64;
	localparam int memAddrWidth = 7;
	localparam int memDepth = 1 << memAddrWidth;
	localparam int delayWidth = 8; // per channel, channel 0 in the low byte
	localparam int chargeWidth = 12;
	localparam int setIdxWidth = 4;
	localparam int waitWidth = 16;
	localparam int pulseCntWidth = 13; // max delay plus max charge time
	localparam int apbAddrWidth = 8;
	localparam int apbDataWidth = 32;

	localparam logic [memAddrWidth-1:0] programBase = 7'd0;
	localparam logic [memAddrWidth-1:0] delayBase = 7'd64; // set n at delayBase + n

	// control/status register, takes the upper half of word 127
	localparam logic [apbAddrWidth-1:0] apbCtrlAddr = 8'hff;

	localparam logic [3:0] opNop = 4'h0;
	localparam logic [3:0] opSetOutputs = 4'h1;
	localparam logic [3:0] opFire = 4'h2;
	localparam logic [3:0] opLoopStart = 4'h3;
	localparam logic [3:0] opLoopEnd = 4'h4;
	localparam logic [3:0] opEnd = 4'h5;

	typedef struct packed {
		logic [7:0] trig;
		logic [7:0] led;
	} outputsView;

	typedef struct packed {
		logic [setIdxWidth-1:0] setIdx;
		logic [chargeWidth-1:0] chargeTime;
	} fireView;

	// meaning of the argument depends on the opcode
	typedef union packed {
		outputsView outputs;
		fireView fire;
		logic [15:0] loopCount;
	} instrArg;

	typedef struct packed {
		logic [3:0] opcode;
		instrArg arg;
		logic [waitWidth-1:0] waitCycles;
		logic [27:0] reserved;
	} instruction;

endpackage
